// ==== Bender.yml ====
package:
  name: dcache_ctrl

sources:
  - files:
      - hdl/dcache_bus_pkg.sv
      - hdl/dcache_ctrl_pkg.sv
      - hdl/dcache_req_queue.sv
      - hdl/dcache_decode.sv
      - hdl/dcache_execute.sv
      - hdl/dcache_result.sv
      - hdl/dcache_ctrl_top.sv
  - target: test
    files:
      - bench/dcache_tb_memory.sv
      - bench/dcache_ctrl_tb.sv

// ==== bench/dcache_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl_tb;
	import dcache_bus_pkg::*;
	import dcache_ctrl_pkg::*;

	localparam int SLOTS      = 4;
	localparam int NUM_REQS   = 80;
	localparam int WAIT_LIMIT = 4000;

	logic                 clk_i;
	logic                 rst_i;
	logic                 dce;
	logic                 hit;
	logic                 bus_full;
	cpu_req_t             cpu_req;
	cpu_resp_t            cpu_resp;
	logic [ADDR_BITS-1:0] lookup_adr;
	line_u                cache_rd_dat;
	cache_wr_t            cache_wr;
	bus_req_t             bus_req;
	bus_resp_t            bus_resp;

	// Open requests, at most one per tid
	cpu_req_t    req_by_tid [16];
	op_kind_e    kind_by_tid [16];
	logic [3:0]  beats_seen [16];
	logic [15:0] pending;
	logic        started;
	logic        timed_out;
	int          err_count;
	int          ack_count;
	logic [31:0] rnd;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Cache content, a different address function than memory
	function automatic logic [BEAT_BITS-1:0] cache_beat(input logic [ADDR_BITS-1:0] adr);
		return {~adr ^ 32'h0f0f_1234, adr + 32'h1111_0000, {adr[7:0], adr[31:8]},
			adr ^ 32'h6b2c_0000};
	endfunction

	function automatic line_u cache_line(input logic [ADDR_BITS-1:0] adr);
		line_u l;
		for (int b = 0; b < BEATS_PER_LINE; b++)
			l.beats[b] = cache_beat({adr[ADDR_BITS-1:6], 2'(b), 4'h0});
		return l;
	endfunction

	function automatic line_u mem_line(input logic [ADDR_BITS-1:0] adr);
		line_u l;
		for (int b = 0; b < BEATS_PER_LINE; b++)
			l.beats[b] = u_mem.beat_pattern({adr[ADDR_BITS-1:6], 2'(b), 4'h0});
		return l;
	endfunction

	// Kind from attribute, hit and direction, cache enabled
	function automatic op_kind_e expected_kind(input cpu_req_t r);
		if (r.attr == ATTR_NC)
			return r.we ? STORE : UNCACHED_READ;
		if (r.adr[12])
			return r.we ? HIT_WRITE : HIT_READ;
		if (r.we)
			return STORE;
		return (r.attr == ATTR_ALLOC) ? MISS_FILL : UNCACHED_READ;
	endfunction

	// Beats that must cross the bus
	function automatic logic [3:0] needed_beats(input op_kind_e k,
		input logic [LINE_BYTES-1:0] sel);
		logic [3:0] m;
		for (int b = 0; b < BEATS_PER_LINE; b++)
			m[b] = |sel[b*BEAT_BYTES +: BEAT_BYTES];
		if (k == MISS_FILL)
			m = 4'hf;
		else if (k == HIT_READ)
			m = 4'h0;
		return m;
	endfunction

	// Queue slot taken while any tid of the same slot is open
	function automatic logic slot_busy(input logic [3:0] tid);
		logic busy;
		busy = 1'b0;
		for (int i = 0; i < 16; i++) begin
			if ((i % SLOTS) == (tid % SLOTS) && pending[i])
				busy = 1'b1;
		end
		return busy;
	endfunction

	task automatic report_problem(input string what);
		err_count++;
		$display("%s", what);
	endtask

	task automatic check_value(input string name, input logic [511:0] got,
		input logic [511:0] exp);
		assert (got === exp)
		else begin
			err_count++;
			$display("[ERROR] %s = %0h, expected %0h", name, got, exp);
		end
	endtask

	// ====================
	// DUT and models
	// ====================

	dcache_ctrl_top #(
		.QUEUE_SLOTS(SLOTS)
	) u_dut (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.dce_i          (dce),
		.cpu_req_i      (cpu_req),
		.cpu_resp_o     (cpu_resp),
		.lookup_adr_o   (lookup_adr),
		.hit_i          (hit),
		.cache_rd_dat_i (cache_rd_dat),
		.cache_wr_o     (cache_wr),
		.bus_req_o      (bus_req),
		.bus_full_i     (bus_full),
		.bus_resp_i     (bus_resp)
	);

	dcache_tb_memory u_mem (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.bus_req_i  (bus_req),
		.bus_full_o (bus_full),
		.bus_resp_o (bus_resp)
	);

	// Tag store answers at once, bit 12 means present
	assign hit          = lookup_adr[12];
	assign cache_rd_dat = cache_line(lookup_adr);

	initial clk_i = 1'b0;
	always #20 clk_i = ~clk_i;

	// ====================
	// Stimulus
	// ====================

	task automatic issue_one(input int n);
		cpu_req_t   r;
		logic [3:0] tid;
		logic [1:0] mode;
		int         waited;
		tid = 4'(n);
		rnd = lcg_next(rnd);
		repeat (1 + rnd[31:30]) @(posedge clk_i);
		waited = 0;
		while (slot_busy(tid) && waited < WAIT_LIMIT) begin
			@(posedge clk_i);
			waited++;
		end
		if (slot_busy(tid)) begin
			report_problem($sformatf("Timeout: tid %0d never found its queue slot free", tid));
			timed_out = 1'b1;
		end else begin
			rnd    = lcg_next(rnd);
			r.vld  = 1'b1;
			r.tid  = tid;
			r.we   = rnd[31];
			r.attr = (rnd[30:29] == 2'd3) ? ATTR_ALLOC : cache_attr_e'(rnd[30:29]);
			rnd    = lcg_next(rnd);
			r.adr  = {rnd[31:6], 6'h0};
			for (int w = 0; w < 16; w++) begin
				rnd = lcg_next(rnd);
				r.dat.bytes[w*4 +: 4] = rnd;
			end
			// Per beat select, empty, full or scattered bytes
			for (int b = 0; b < BEATS_PER_LINE; b++) begin
				rnd  = lcg_next(rnd);
				mode = rnd[31:30];
				if (mode == 2'd0)
					r.sel[b*BEAT_BYTES +: BEAT_BYTES] = '0;
				else if (mode == 2'd1)
					r.sel[b*BEAT_BYTES +: BEAT_BYTES] = '1;
				else
					r.sel[b*BEAT_BYTES +: BEAT_BYTES] = rnd[23:8];
			end
			req_by_tid[tid]  = r;
			kind_by_tid[tid] = expected_kind(r);
			cpu_req      <= r;
			pending[tid] <= 1'b1;
			started      <= 1'b1;
			@(posedge clk_i);
			cpu_req.vld <= 1'b0;
		end
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (pending != '0 && waited < WAIT_LIMIT) begin
			@(posedge clk_i);
			waited++;
		end
		if (pending != '0) begin
			report_problem($sformatf("Timeout: requests still open at the end, tids %h", pending));
			timed_out = 1'b1;
		end
	endtask

	initial begin
		rst_i     = 1'b1;
		dce       = 1'b1;
		cpu_req   = '0;
		pending   = '0;
		started   = 1'b0;
		timed_out = 1'b0;
		err_count = 0;
		ack_count = 0;
		rnd       = 32'h2eb67834;
		for (int i = 0; i < 16; i++)
			beats_seen[i] = '0;
		repeat (5) @(posedge clk_i);
		rst_i <= 1'b0;
		for (int n = 0; n < NUM_REQS; n++) begin
			if (!timed_out)
				issue_one(n);
		end
		if (!timed_out)
			wait_idle();
		repeat (4) @(posedge clk_i);
		check_value("ack count", ack_count, NUM_REQS);
		$display("Requests %0d, acks %0d, errors %0d", NUM_REQS, ack_count, err_count);
		if (err_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// ====================
	// Checking
	// ====================

	// Back-pressure, no strobe right after a full cycle
	a_full_gap: assert property (@(posedge clk_i) disable iff (rst_i)
		bus_full |=> !bus_req.cyc)
	else begin
		err_count++;
		$display("[ERROR] bus_req_o.cyc = %0h after bus_full_i, expected 0",
			$sampled(bus_req.cyc));
	end

	always @(posedge clk_i) begin : monitor
		cpu_req_t   r;
		op_kind_e   k;
		line_u      mline;
		line_u      cline;
		line_u      merged;
		logic [3:0] need;
		int         t;
		int         bt;
		// Quiet outputs between reset and the first request
		if (!rst_i && !started) begin
			check_value("bus_req_o.cyc", bus_req.cyc, 1'b0);
			check_value("cpu_resp_o.ack", cpu_resp.ack, 1'b0);
			check_value("cache_wr_o.wr", cache_wr.wr, 1'b0);
		end
		// Every bus beat belongs to an open request and a needed beat
		if (!rst_i && bus_req.cyc) begin
			t    = bus_req.tag.tid;
			bt   = bus_req.tag.beat;
			r    = req_by_tid[t];
			k    = kind_by_tid[t];
			need = needed_beats(k, r.sel);
			assert (pending[t] && need[bt] && !beats_seen[t][bt])
			else report_problem($sformatf("Unexpected bus beat %0d for tid %0d", bt, t));
			beats_seen[t][bt] = 1'b1;
			check_value("bus_req_o.adr", bus_req.adr, {r.adr[ADDR_BITS-1:6], 2'(bt), 4'h0});
			if (k == STORE || k == HIT_WRITE) begin
				check_value("bus_req_o.we", bus_req.we, 1'b1);
				check_value("bus_req_o.cmd", bus_req.cmd, CMD_STORE);
				check_value("bus_req_o.sel", bus_req.sel, r.sel[bt*BEAT_BYTES +: BEAT_BYTES]);
				check_value("bus_req_o.dat", bus_req.dat, r.dat.beats[bt]);
			end else begin
				check_value("bus_req_o.we", bus_req.we, 1'b0);
				check_value("bus_req_o.cmd", bus_req.cmd,
					(k == MISS_FILL) ? CMD_LINE_LOAD : CMD_LOAD);
			end
		end
		assert (rst_i || !cache_wr.wr || cpu_resp.ack)
		else report_problem("Cache write outside a CPU ack");
		// One ack per request, data and cache write by kind
		if (!rst_i && cpu_resp.ack) begin
			t     = cpu_resp.tid;
			r     = req_by_tid[t];
			k     = kind_by_tid[t];
			need  = needed_beats(k, r.sel);
			mline = mem_line(r.adr);
			cline = cache_line(r.adr);
			ack_count++;
			assert (pending[t])
			else report_problem($sformatf("Ack for tid %0d, which has no open request", t));
			pending[t] <= 1'b0;
			check_value("bus_req_o beats", beats_seen[t], need);
			beats_seen[t] = '0;
			// Hits read the tag store at the held line
			if (k == HIT_READ || k == HIT_WRITE)
				check_value("lookup_adr_o", lookup_adr, r.adr);
			for (int b = 0; b < LINE_BYTES; b++)
				merged.bytes[b] = r.sel[b] ? r.dat.bytes[b] : cline.bytes[b];
			case (k)
				HIT_READ:  check_value("cpu_resp_o.dat", cpu_resp.dat, cline);
				MISS_FILL: check_value("cpu_resp_o.dat", cpu_resp.dat, mline);
				UNCACHED_READ: begin
					for (int b = 0; b < BEATS_PER_LINE; b++) begin
						if (need[b])
							check_value("cpu_resp_o.dat", cpu_resp.dat.beats[b], mline.beats[b]);
					end
				end
				default: ;
			endcase
			check_value("cache_wr_o.wr", cache_wr.wr, k == MISS_FILL || k == HIT_WRITE);
			if (k == MISS_FILL || k == HIT_WRITE) begin
				check_value("cache_wr_o.load", cache_wr.load, k == MISS_FILL);
				check_value("cache_wr_o.adr", cache_wr.adr, r.adr);
				check_value("cache_wr_o.dat", cache_wr.dat, (k == MISS_FILL) ? mline : merged);
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/dcache_tb_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb_memory (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  dcache_bus_pkg::bus_req_t  bus_req_i,
	output logic                      bus_full_o,
	output dcache_bus_pkg::bus_resp_t bus_resp_o
);
	import dcache_bus_pkg::*;

	localparam logic [31:0] SEED = 32'h2eb67834;

	// Read beats waiting for their response
	bus_tag_t             tag_q [$];
	logic [ADDR_BITS-1:0] adr_q [$];
	int                   delay_q [$];

	logic [31:0] rnd    = SEED;
	logic        full_q = 1'b0;
	bus_resp_t   resp_q = '0;

	assign bus_full_o = full_q;
	assign bus_resp_o = resp_q;

	// Memory content, each beat a function of its whole address
	function automatic logic [BEAT_BITS-1:0] beat_pattern(input logic [ADDR_BITS-1:0] adr);
		return {adr ^ 32'h5a5a_0000, ~adr, adr * 32'd3 + 32'd7,
			{adr[15:0], adr[31:16]} ^ 32'hc3c3_3c3c};
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ====================
	// Responder
	// ====================

	always @(posedge clk_i) begin : respond
		int pick;
		if (rst_i) begin
			rnd = SEED;
			full_q <= 1'b0;
			resp_q <= '0;
			tag_q.delete();
			adr_q.delete();
			delay_q.delete();
		end else begin
			rnd = lcg_next(rnd);
			// Full about one cycle in four
			full_q     <= (rnd[31:30] == 2'd0);
			resp_q.ack <= 1'b0;
			// First expired entry answers, later ones may overtake earlier ones
			pick = -1;
			for (int i = 0; i < delay_q.size(); i++) begin
				if (delay_q[i] == 0 && pick < 0)
					pick = i;
				else if (delay_q[i] > 0)
					delay_q[i]--;
			end
			if (pick >= 0) begin
				resp_q.ack <= 1'b1;
				resp_q.tag <= tag_q[pick];
				resp_q.adr <= adr_q[pick];
				resp_q.dat <= beat_pattern(adr_q[pick]);
				tag_q.delete(pick);
				adr_q.delete(pick);
				delay_q.delete(pick);
			end
			// Stores finish on issue and get no response
			if (bus_req_i.cyc && !bus_req_i.we) begin
				tag_q.push_back(bus_req_i.tag);
				adr_q.push_back(bus_req_i.adr);
				delay_q.push_back(int'(rnd[27:25]));
			end
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/dcache_bus_pkg.sv
hdl/dcache_ctrl_pkg.sv
hdl/dcache_req_queue.sv
hdl/dcache_decode.sv
hdl/dcache_execute.sv
hdl/dcache_result.sv
hdl/dcache_ctrl_top.sv
bench/dcache_tb_memory.sv
bench/dcache_ctrl_tb.sv

// ==== hdl/dcache_bus_pkg.sv ====
`default_nettype none

package dcache_bus_pkg;

	// ====================
	// Bus geometry
	// ====================

	// One beat is a quarter of a cache line
	localparam int BEAT_BITS      = 128;
	localparam int BEAT_BYTES     = 16;
	localparam int ADDR_BITS      = 32;
	localparam int BEATS_PER_LINE = 4;

	// Bus commands
	typedef enum logic [1:0] {
		CMD_LOAD      = 2'd0,
		CMD_LINE_LOAD = 2'd1,
		CMD_STORE     = 2'd2
	} bus_cmd_e;

	// Tag travels out with a beat and comes back with its response
	typedef struct packed {
		logic [3:0] tid;
		logic [1:0] beat;
	} bus_tag_t;

	// ====================
	// Request and response
	// ====================

	// Request beat, cyc is a single cycle strobe
	typedef struct packed {
		logic                  cyc;
		logic                  we;
		bus_cmd_e              cmd;
		bus_tag_t              tag;
		logic [ADDR_BITS-1:0]  adr;
		logic [BEAT_BYTES-1:0] sel;
		logic [BEAT_BITS-1:0]  dat;
	} bus_req_t;

	// Response beat, ack pulses once per beat
	typedef struct packed {
		logic                 ack;
		bus_tag_t             tag;
		logic [ADDR_BITS-1:0] adr;
		logic [BEAT_BITS-1:0] dat;
	} bus_resp_t;

endpackage

`default_nettype wire

// ==== hdl/dcache_ctrl_pkg.sv ====
`default_nettype none

package dcache_ctrl_pkg;

	// Bytes in one cache line
	localparam int LINE_BYTES = 64;

	// Cache attribute carried by each CPU request
	typedef enum logic [1:0] {
		ATTR_ALLOC    = 2'd0,
		ATTR_NO_ALLOC = 2'd1,
		ATTR_NC       = 2'd2
	} cache_attr_e;

	// ====================
	// Line views
	// ====================

	// Bytes for store merging, beats for fill and issue
	typedef union packed {
		logic [LINE_BYTES-1:0][7:0] bytes;
		logic [dcache_bus_pkg::BEATS_PER_LINE-1:0][dcache_bus_pkg::BEAT_BITS-1:0] beats;
	} line_u;

	// CPU request, one line wide
	typedef struct packed {
		logic                                vld;
		logic [3:0]                          tid;
		logic                                we;
		cache_attr_e                         attr;
		logic [dcache_bus_pkg::ADDR_BITS-1:0] adr;
		logic [LINE_BYTES-1:0]               sel;
		line_u                               dat;
	} cpu_req_t;

	// CPU response, ack is a one cycle pulse
	typedef struct packed {
		logic       ack;
		logic [3:0] tid;
		line_u      dat;
	} cpu_resp_t;

	// ====================
	// Decoded operation
	// ====================

	typedef enum logic [2:0] {
		HIT_READ      = 3'd0,
		HIT_WRITE     = 3'd1,
		MISS_FILL     = 3'd2,
		UNCACHED_READ = 3'd3,
		STORE         = 3'd4
	} op_kind_e;

	// Operation held by decode until result finishes it
	typedef struct packed {
		logic                                      vld;
		op_kind_e                                  kind;
		logic [3:0]                                tid;
		logic [dcache_bus_pkg::ADDR_BITS-1:0]      adr;
		logic [LINE_BYTES-1:0]                     sel;
		line_u                                     dat;
		logic [dcache_bus_pkg::BEATS_PER_LINE-1:0] beat_mask;
	} line_op_t;

	// Cache write port, load marks a line fill
	typedef struct packed {
		logic                                wr;
		logic                                load;
		logic [dcache_bus_pkg::ADDR_BITS-1:0] adr;
		line_u                               dat;
	} cache_wr_t;

endpackage

`default_nettype wire

// ==== hdl/dcache_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl_top #(
	parameter int QUEUE_SLOTS = 4
) (
	input  logic                                 clk_i,
	input  logic                                 rst_i,
	input  logic                                 dce_i,
	input  dcache_ctrl_pkg::cpu_req_t            cpu_req_i,
	output dcache_ctrl_pkg::cpu_resp_t           cpu_resp_o,
	output logic [dcache_bus_pkg::ADDR_BITS-1:0] lookup_adr_o,
	input  logic                                 hit_i,
	input  dcache_ctrl_pkg::line_u               cache_rd_dat_i,
	output dcache_ctrl_pkg::cache_wr_t           cache_wr_o,
	output dcache_bus_pkg::bus_req_t             bus_req_o,
	input  logic                                 bus_full_i,
	input  dcache_bus_pkg::bus_resp_t            bus_resp_i
);
	import dcache_bus_pkg::*;
	import dcache_ctrl_pkg::*;

	// ====================
	// Stage links
	// ====================

	cpu_req_t                  take_req;
	logic                      op_free;
	line_op_t                  cur_op;
	logic [BEATS_PER_LINE-1:0] beat_done;
	logic                      op_done;

	// Request capture
	dcache_req_queue #(
		.QUEUE_SLOTS(QUEUE_SLOTS)
	) u_queue (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.cpu_req_i  (cpu_req_i),
		.op_free_i  (op_free),
		.take_req_o (take_req)
	);

	// Classify and hold one operation
	dcache_decode u_decode (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.take_req_i   (take_req),
		.dce_i        (dce_i),
		.hit_i        (hit_i),
		.op_done_i    (op_done),
		.op_free_o    (op_free),
		.lookup_adr_o (lookup_adr_o),
		.cur_op_o     (cur_op)
	);

	// Bus beats
	dcache_execute u_execute (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cur_op_i    (cur_op),
		.op_done_i   (op_done),
		.bus_full_i  (bus_full_i),
		.bus_resp_i  (bus_resp_i),
		.bus_req_o   (bus_req_o),
		.beat_done_o (beat_done)
	);

	// Line assembly, cache write and CPU ack
	dcache_result u_result (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.cur_op_i       (cur_op),
		.beat_done_i    (beat_done),
		.bus_resp_i     (bus_resp_i),
		.cache_rd_dat_i (cache_rd_dat_i),
		.cpu_resp_o     (cpu_resp_o),
		.cache_wr_o     (cache_wr_o),
		.op_done_o      (op_done)
	);

endmodule

`default_nettype wire

// ==== hdl/dcache_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_decode (
	input  logic                                 clk_i,
	input  logic                                 rst_i,
	input  dcache_ctrl_pkg::cpu_req_t            take_req_i,
	input  logic                                 dce_i,
	input  logic                                 hit_i,
	input  logic                                 op_done_i,
	output logic                                 op_free_o,
	output logic [dcache_bus_pkg::ADDR_BITS-1:0] lookup_adr_o,
	output dcache_ctrl_pkg::line_op_t            cur_op_o
);
	import dcache_bus_pkg::*;
	import dcache_ctrl_pkg::*;

	logic                      non_cacheable;
	op_kind_e                  kind;
	logic [BEATS_PER_LINE-1:0] slice_mask;
	logic [BEATS_PER_LINE-1:0] beat_mask;
	logic                      op_vld_q;
	line_op_t                  op_q;

	// ====================
	// Classify
	// ====================

	// Cache off or a non-cacheable page bypasses the tags
	always_comb begin
		non_cacheable = !dce_i || (take_req_i.attr == ATTR_NC);
		if (non_cacheable)
			kind = take_req_i.we ? STORE : UNCACHED_READ;
		else if (hit_i)
			kind = take_req_i.we ? HIT_WRITE : HIT_READ;
		else if (take_req_i.we)
			kind = STORE;
		else if (take_req_i.attr == ATTR_ALLOC)
			kind = MISS_FILL;
		else
			kind = UNCACHED_READ;
	end

	// Beat needed where its select slice has any byte
	always_comb begin
		for (int b = 0; b < BEATS_PER_LINE; b++)
			slice_mask[b] = |take_req_i.sel[b*BEAT_BYTES +: BEAT_BYTES];
		case (kind)
			MISS_FILL: beat_mask = '1;
			HIT_READ:  beat_mask = '0;
			default:   beat_mask = slice_mask;
		endcase
	end

	// Tag lookup follows the incoming request, then the held one
	assign lookup_adr_o = take_req_i.vld ? take_req_i.adr : op_q.adr;

	// ====================
	// Operation register
	// ====================

	always_ff @(posedge clk_i) begin
		if (rst_i)
			op_vld_q <= 1'b0;
		else if (take_req_i.vld)
			op_vld_q <= 1'b1;
		else if (op_done_i)
			op_vld_q <= 1'b0;
	end

	// hit_i only counts in the take cycle
	always_ff @(posedge clk_i) begin
		if (take_req_i.vld) begin
			op_q.vld       <= 1'b1;
			op_q.kind      <= kind;
			op_q.tid       <= take_req_i.tid;
			op_q.adr       <= take_req_i.adr;
			op_q.sel       <= take_req_i.sel;
			op_q.dat       <= take_req_i.dat;
			op_q.beat_mask <= beat_mask;
		end
	end

	always_comb begin
		cur_op_o     = op_q;
		cur_op_o.vld = op_vld_q;
	end

	assign op_free_o = !op_vld_q;

endmodule

`default_nettype wire

// ==== hdl/dcache_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_execute (
	input  logic                                      clk_i,
	input  logic                                      rst_i,
	input  dcache_ctrl_pkg::line_op_t                 cur_op_i,
	input  logic                                      op_done_i,
	input  logic                                      bus_full_i,
	input  dcache_bus_pkg::bus_resp_t                 bus_resp_i,
	output dcache_bus_pkg::bus_req_t                  bus_req_o,
	output logic [dcache_bus_pkg::BEATS_PER_LINE-1:0] beat_done_o
);
	import dcache_bus_pkg::*;
	import dcache_ctrl_pkg::*;

	logic                      is_write;
	logic [BEATS_PER_LINE-1:0] issued_q;
	logic [BEATS_PER_LINE-1:0] done_q;
	logic                      pick_vld;
	logic [1:0]                pick;
	logic                      issue;
	logic [BEATS_PER_LINE-1:0] issue_done;
	logic [BEATS_PER_LINE-1:0] resp_done;
	logic                      cyc_q;
	bus_req_t                  beat_q;

	assign is_write = (cur_op_i.kind == HIT_WRITE) || (cur_op_i.kind == STORE);

	// ====================
	// Beat issue
	// ====================

	// Lowest masked beat not yet sent
	always_comb begin
		pick_vld = 1'b0;
		pick     = '0;
		for (int i = BEATS_PER_LINE - 1; i >= 0; i--) begin
			if (cur_op_i.beat_mask[i] && !issued_q[i]) begin
				pick_vld = 1'b1;
				pick     = 2'(i);
			end
		end
	end

	// Full only holds the beat back, it stays pending
	assign issue = cur_op_i.vld && pick_vld && !bus_full_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cyc_q    <= 1'b0;
			issued_q <= '0;
		end else begin
			cyc_q <= issue;
			if (op_done_i)
				issued_q <= '0;
			else if (issue)
				issued_q[pick] <= 1'b1;
		end
	end

	// Beat payload, beat number lands in adr[5:4]
	always_ff @(posedge clk_i) begin
		if (issue) begin
			beat_q.cyc      <= 1'b1;
			beat_q.we       <= is_write;
			beat_q.cmd      <= is_write ? CMD_STORE :
				(cur_op_i.kind == MISS_FILL) ? CMD_LINE_LOAD : CMD_LOAD;
			beat_q.tag.tid  <= cur_op_i.tid;
			beat_q.tag.beat <= pick;
			beat_q.adr      <= {cur_op_i.adr[ADDR_BITS-1:6], pick, 4'h0};
			beat_q.sel      <= cur_op_i.sel[pick*BEAT_BYTES +: BEAT_BYTES];
			beat_q.dat      <= cur_op_i.dat.beats[pick];
		end
	end

	always_comb begin
		bus_req_o     = beat_q;
		bus_req_o.cyc = cyc_q;
	end

	// ====================
	// Beat completion
	// ====================

	// Stores finish on issue, reads on their own response
	always_comb begin
		issue_done = '0;
		resp_done  = '0;
		if (issue && is_write)
			issue_done[pick] = 1'b1;
		if (!is_write && bus_resp_i.ack && bus_resp_i.tag.tid == cur_op_i.tid)
			resp_done[bus_resp_i.tag.beat] = 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			done_q <= '0;
		else if (op_done_i)
			done_q <= '0;
		else if (cur_op_i.vld)
			// Unmasked beats count as done right away
			done_q <= done_q | ~cur_op_i.beat_mask | issue_done | resp_done;
	end

	assign beat_done_o = done_q;

	// No bus strobe right after a full cycle, and the held beat stays pending
	a_full_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		(bus_full_i && cur_op_i.vld && pick_vld) |=>
			(!bus_req_o.cyc && cur_op_i.vld && pick_vld));

endmodule

`default_nettype wire

// ==== hdl/dcache_req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_req_queue #(
	parameter int QUEUE_SLOTS = 4
) (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  dcache_ctrl_pkg::cpu_req_t cpu_req_i,
	input  logic                      op_free_i,
	output dcache_ctrl_pkg::cpu_req_t take_req_o
);
	import dcache_ctrl_pkg::*;

	localparam int IDX_BITS = $clog2(QUEUE_SLOTS);

	// Slot storage and its valid bits
	cpu_req_t               slot_q [QUEUE_SLOTS];
	logic [QUEUE_SLOTS-1:0] slot_vld_q;
	logic [IDX_BITS-1:0]    wr_idx;
	logic [IDX_BITS-1:0]    pick;
	logic                   take;

	// Slot comes from the low tid bits
	assign wr_idx = cpu_req_i.tid[IDX_BITS-1:0];

	// ====================
	// Slot select
	// ====================

	// Highest valid slot wins
	always_comb begin
		pick = '0;
		for (int i = 0; i < QUEUE_SLOTS; i++) begin
			if (slot_vld_q[i])
				pick = IDX_BITS'(i);
		end
	end

	// Hand over only while decode is empty
	assign take = (|slot_vld_q) && op_free_i;

	always_comb begin
		take_req_o     = slot_q[pick];
		take_req_o.vld = take;
	end

	// ====================
	// Slot update
	// ====================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			slot_vld_q <= '0;
		end else begin
			if (take)
				slot_vld_q[pick] <= 1'b0;
			// A new request into the same slot survives the take
			if (cpu_req_i.vld)
				slot_vld_q[wr_idx] <= 1'b1;
		end
	end

	// Same index simply overwrites
	always_ff @(posedge clk_i) begin
		if (cpu_req_i.vld)
			slot_q[wr_idx] <= cpu_req_i;
	end

	// Take only into a free decode, which then holds the operation
	a_take_free: assert property (@(posedge clk_i) disable iff (rst_i)
		take_req_o.vld |-> op_free_i ##1 !op_free_i);

endmodule

`default_nettype wire

// ==== hdl/dcache_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_result (
	input  logic                                      clk_i,
	input  logic                                      rst_i,
	input  dcache_ctrl_pkg::line_op_t                 cur_op_i,
	input  logic [dcache_bus_pkg::BEATS_PER_LINE-1:0] beat_done_i,
	input  dcache_bus_pkg::bus_resp_t                 bus_resp_i,
	input  dcache_ctrl_pkg::line_u                    cache_rd_dat_i,
	output dcache_ctrl_pkg::cpu_resp_t                cpu_resp_o,
	output dcache_ctrl_pkg::cache_wr_t                cache_wr_o,
	output logic                                      op_done_o
);
	import dcache_ctrl_pkg::*;

	logic  done;
	logic  is_fill;
	line_u fill_q;
	line_u merged;

	// ====================
	// Read assembly
	// ====================

	// Each response drops into its own beat
	always_ff @(posedge clk_i) begin
		if (cur_op_i.vld && bus_resp_i.ack && bus_resp_i.tag.tid == cur_op_i.tid)
			fill_q.beats[bus_resp_i.tag.beat] <= bus_resp_i.dat;
	end

	// Write hit merge
	// CPU byte where selected, cache byte elsewhere
	always_comb begin
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (cur_op_i.sel[b])
				merged.bytes[b] = cur_op_i.dat.bytes[b];
			else
				merged.bytes[b] = cache_rd_dat_i.bytes[b];
		end
	end

	// ====================
	// Completion
	// ====================

	// All four beats done ends the operation
	assign done      = cur_op_i.vld && (&beat_done_i);
	assign is_fill   = (cur_op_i.kind == MISS_FILL);
	assign op_done_o = done;

	// Hits read straight from the cache, everything else from the buffer
	always_comb begin
		cpu_resp_o.ack = done;
		cpu_resp_o.tid = cur_op_i.tid;
		if (cur_op_i.kind == HIT_READ)
			cpu_resp_o.dat = cache_rd_dat_i;
		else
			cpu_resp_o.dat = fill_q;
	end

	// Fills load the line, write hits update it through
	always_comb begin
		cache_wr_o.wr   = done && (is_fill || cur_op_i.kind == HIT_WRITE);
		cache_wr_o.load = is_fill;
		cache_wr_o.adr  = cur_op_i.adr;
		cache_wr_o.dat  = is_fill ? fill_q : merged;
	end

	// Decode and execute both drop the operation after done
	a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		op_done_o |=> !op_done_o);

endmodule

`default_nettype wire
